/* hdl/tlb_macros.svh */
`ifndef TLB_MACROS_SVH
`define TLB_MACROS_SVH

// geometry
`define TLB_NWAY  4
`define TLB_NSET  8
`define TLB_IDX_W 5

// supported page sizes, log2 bytes
`define TLB_PS_4K 12
`define TLB_PS_4M 22

`endif

/* hdl/tlb_pkg.sv */
package tlb_pkg;

    // one stored entry, valid bit e lives in tlb_valid_ctrl
    typedef struct packed {
        logic [18:0] vppn;
        logic [5:0]  ps;
        logic        g;
        logic [9:0]  asid;
        // odd half
        logic [19:0] ppn1;
        logic [1:0]  plv1;
        logic [1:0]  mat1;
        logic        d1;
        logic        v1;
        // even half
        logic [19:0] ppn0;
        logic [1:0]  plv0;
        logic [1:0]  mat0;
        logic        d0;
        logic        v0;
    } tlb_entry_t;

    // invtlb operations
    typedef enum logic [4:0] {
        INV_ALL        = 5'd0,
        INV_ALL_ALT    = 5'd1,
        INV_GLOBAL     = 5'd2,
        INV_NONGLOBAL  = 5'd3,
        INV_ASID       = 5'd4,
        INV_ASID_PAGE  = 5'd5,
        INV_GASID_PAGE = 5'd6
    } tlb_inv_op_e;

endpackage

/* hdl/tlb_search_stage.sv */
`timescale 1ns/1ps
`include "tlb_macros.svh"

module tlb_search_stage (
    input  logic                   clk,
    input  logic                   reset_i,
    input  logic                   fetch_i,
    input  logic [18:0]            vppn_i,
    input  logic                   odd_page_i,
    input  logic [9:0]             asid_i,
    input  logic [`TLB_NWAY-1:0]   valid_i,
    input  tlb_pkg::tlb_entry_t    way_entry_i [`TLB_NWAY],
    output logic                   found_o,
    output logic [`TLB_IDX_W-1:0]  index_o,
    output logic [5:0]             ps_o,
    output logic [19:0]            ppn_o,
    output logic                   v_o,
    output logic                   d_o,
    output logic [1:0]             mat_o,
    output logic [1:0]             plv_o
);

    localparam int SET_W = $clog2(`TLB_NSET);
    localparam int WAY_W = $clog2(`TLB_NWAY);

    logic [`TLB_NWAY-1:0] match_c;
    logic [`TLB_NWAY-1:0] odd_c;
    logic [`TLB_NWAY-1:0] match_q;
    logic [`TLB_NWAY-1:0] odd_q;
    tlb_pkg::tlb_entry_t  entry_q [`TLB_NWAY];
    logic [SET_W-1:0]     set_q;
    logic [WAY_W-1:0]     hit_way;
    logic                 hit_odd;
    tlb_pkg::tlb_entry_t  hit_entry;

    // compare all ways of the addressed set
    always_comb begin
        for (int i = 0; i < `TLB_NWAY; i++) begin
            match_c[i] = 1'b0;
            odd_c[i]   = odd_page_i;
            if (way_entry_i[i].ps == 6'(`TLB_PS_4K)) begin
                match_c[i] = way_entry_i[i].vppn == vppn_i;
            end else if (way_entry_i[i].ps == 6'(`TLB_PS_4M)) begin
                match_c[i] = way_entry_i[i].vppn[18:9] == vppn_i[18:9];
                odd_c[i]   = vppn_i[8];  // 2MB halves
            end
            match_c[i] = match_c[i] && valid_i[i] &&
                         (way_entry_i[i].g || way_entry_i[i].asid == asid_i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            match_q <= '0;
        end else if (fetch_i) begin
            match_q <= match_c;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_i) begin
            odd_q   <= odd_c;
            entry_q <= way_entry_i;
            set_q   <= vppn_i[9 +: SET_W];
        end
    end

    // highest matching way wins
    always_comb begin
        hit_way = '0;
        for (int i = 0; i < `TLB_NWAY; i++) begin
            if (match_q[i]) hit_way = WAY_W'(i);
        end
    end

    assign hit_odd   = odd_q[hit_way];
    assign hit_entry = entry_q[hit_way];

    assign found_o = |match_q;
    assign index_o = {hit_way, set_q};
    assign ps_o    = hit_entry.ps;
    assign ppn_o   = hit_odd ? hit_entry.ppn1 : hit_entry.ppn0;
    assign v_o     = hit_odd ? hit_entry.v1   : hit_entry.v0;
    assign d_o     = hit_odd ? hit_entry.d1   : hit_entry.d0;
    assign mat_o   = hit_odd ? hit_entry.mat1 : hit_entry.mat0;
    assign plv_o   = hit_odd ? hit_entry.plv1 : hit_entry.plv0;

endmodule

/* hdl/tlb_top.sv */
`timescale 1ns/1ps
`include "tlb_macros.svh"

module tlb_top (
    input  logic                   clk,
    input  logic                   reset_i,
    // fetch side search
    input  logic                   s0_fetch_i,
    input  logic [18:0]            s0_vppn_i,
    input  logic                   s0_odd_page_i,
    input  logic [9:0]             s0_asid_i,
    output logic                   s0_found_o,
    output logic [`TLB_IDX_W-1:0]  s0_index_o,
    output logic [5:0]             s0_ps_o,
    output logic [19:0]            s0_ppn_o,
    output logic                   s0_v_o,
    output logic                   s0_d_o,
    output logic [1:0]             s0_mat_o,
    output logic [1:0]             s0_plv_o,
    // data side search
    input  logic                   s1_fetch_i,
    input  logic [18:0]            s1_vppn_i,
    input  logic                   s1_odd_page_i,
    input  logic [9:0]             s1_asid_i,
    output logic                   s1_found_o,
    output logic [`TLB_IDX_W-1:0]  s1_index_o,
    output logic [5:0]             s1_ps_o,
    output logic [19:0]            s1_ppn_o,
    output logic                   s1_v_o,
    output logic                   s1_d_o,
    output logic [1:0]             s1_mat_o,
    output logic [1:0]             s1_plv_o,
    // write
    input  logic                   we_i,
    input  logic [`TLB_IDX_W-1:0]  w_index_i,
    input  tlb_pkg::tlb_entry_t    w_entry_i,
    input  logic                   w_e_i,
    // read, same cycle
    input  logic [`TLB_IDX_W-1:0]  r_index_i,
    output tlb_pkg::tlb_entry_t    r_entry_o,
    output logic                   r_e_o,
    // invalidate
    input  logic                   inv_en_i,
    input  tlb_pkg::tlb_inv_op_e   inv_op_i,
    input  logic [9:0]             inv_asid_i,
    input  logic [18:0]            inv_vppn_i,
    output logic                   inv_stall_o
);

    localparam int SET_W = $clog2(`TLB_NSET);
    localparam int WAY_W = $clog2(`TLB_NWAY);

    tlb_pkg::tlb_entry_t            s0_entry [`TLB_NWAY];
    tlb_pkg::tlb_entry_t            s1_entry [`TLB_NWAY];
    tlb_pkg::tlb_entry_t            m_entry  [`TLB_NWAY];
    logic [`TLB_NWAY*`TLB_NSET-1:0] valid;
    logic [`TLB_NWAY-1:0]           s0_valid;
    logic [`TLB_NWAY-1:0]           s1_valid;
    logic [`TLB_NWAY-1:0]           way_we;
    logic [SET_W-1:0]               s0_set;
    logic [SET_W-1:0]               s1_set;
    logic [SET_W-1:0]               m_set;

    // set index is vppn[11:9] for both page sizes
    assign s0_set = s0_vppn_i[9 +: SET_W];
    assign s1_set = s1_vppn_i[9 +: SET_W];

    for (genvar g = 0; g < `TLB_NWAY; g++) begin : g_way
        assign way_we[g]   = we_i && (w_index_i[`TLB_IDX_W-1:SET_W] == WAY_W'(g));
        assign s0_valid[g] = valid[{WAY_W'(g), s0_set}];
        assign s1_valid[g] = valid[{WAY_W'(g), s1_set}];

        tlb_way_ram u_way (
            .clk        (clk),
            .s0_set_i   (s0_set),
            .s1_set_i   (s1_set),
            .m_set_i    (m_set),
            .we_i       (way_we[g]),
            .w_set_i    (w_index_i[SET_W-1:0]),
            .w_entry_i  (w_entry_i),
            .s0_entry_o (s0_entry[g]),
            .s1_entry_o (s1_entry[g]),
            .m_entry_o  (m_entry[g])
        );
    end

    tlb_search_stage search0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .fetch_i     (s0_fetch_i),
        .vppn_i      (s0_vppn_i),
        .odd_page_i  (s0_odd_page_i),
        .asid_i      (s0_asid_i),
        .valid_i     (s0_valid),
        .way_entry_i (s0_entry),
        .found_o     (s0_found_o),
        .index_o     (s0_index_o),
        .ps_o        (s0_ps_o),
        .ppn_o       (s0_ppn_o),
        .v_o         (s0_v_o),
        .d_o         (s0_d_o),
        .mat_o       (s0_mat_o),
        .plv_o       (s0_plv_o)
    );

    tlb_search_stage search1 (
        .clk         (clk),
        .reset_i     (reset_i),
        .fetch_i     (s1_fetch_i),
        .vppn_i      (s1_vppn_i),
        .odd_page_i  (s1_odd_page_i),
        .asid_i      (s1_asid_i),
        .valid_i     (s1_valid),
        .way_entry_i (s1_entry),
        .found_o     (s1_found_o),
        .index_o     (s1_index_o),
        .ps_o        (s1_ps_o),
        .ppn_o       (s1_ppn_o),
        .v_o         (s1_v_o),
        .d_o         (s1_d_o),
        .mat_o       (s1_mat_o),
        .plv_o       (s1_plv_o)
    );

    tlb_valid_ctrl u_valid (
        .clk         (clk),
        .reset_i     (reset_i),
        .we_i        (we_i),
        .w_index_i   (w_index_i),
        .w_e_i       (w_e_i),
        .inv_en_i    (inv_en_i),
        .inv_op_i    (inv_op_i),
        .inv_asid_i  (inv_asid_i),
        .inv_vppn_i  (inv_vppn_i),
        .r_set_i     (r_index_i[SET_W-1:0]),
        .m_entry_i   (m_entry),
        .valid_o     (valid),
        .m_set_o     (m_set),
        .inv_stall_o (inv_stall_o)
    );

    // read port shares the maintenance read of each way
    assign r_entry_o = m_entry[r_index_i[`TLB_IDX_W-1:SET_W]];
    assign r_e_o     = valid[r_index_i];

endmodule

/* hdl/tlb_valid_ctrl.sv */
`timescale 1ns/1ps
`include "tlb_macros.svh"

module tlb_valid_ctrl (
    input  logic                                   clk,
    input  logic                                   reset_i,
    input  logic                                   we_i,
    input  logic [`TLB_IDX_W-1:0]                  w_index_i,
    input  logic                                   w_e_i,
    input  logic                                   inv_en_i,
    input  tlb_pkg::tlb_inv_op_e                   inv_op_i,
    input  logic [9:0]                             inv_asid_i,
    input  logic [18:0]                            inv_vppn_i,
    input  logic [$clog2(`TLB_NSET)-1:0]           r_set_i,
    input  tlb_pkg::tlb_entry_t                    m_entry_i [`TLB_NWAY],
    output logic [`TLB_NWAY*`TLB_NSET-1:0]         valid_o,
    output logic [$clog2(`TLB_NSET)-1:0]           m_set_o,
    output logic                                   inv_stall_o
);

    localparam int SET_W = $clog2(`TLB_NSET);
    localparam int WAY_W = $clog2(`TLB_NWAY);

    logic [`TLB_NWAY*`TLB_NSET-1:0] valid_q;
    logic [SET_W-1:0]               cnt_q;
    logic                           done_q;
    logic                           inv_step;
    logic [`TLB_NWAY-1:0]           clr;

    function automatic logic page_match(input tlb_pkg::tlb_entry_t ent,
                                        input logic [18:0] vppn);
        if (ent.ps == 6'(`TLB_PS_4K)) begin
            return ent.vppn == vppn;
        end
        return ent.vppn[18:9] == vppn[18:9];
    endfunction

    // one set per cycle until set 7 is done
    assign inv_step    = inv_en_i && !done_q;
    assign inv_stall_o = inv_step;
    assign m_set_o     = inv_en_i ? cnt_q : r_set_i;

    always_comb begin
        for (int i = 0; i < `TLB_NWAY; i++) begin
            case (inv_op_i)
                tlb_pkg::INV_ALL, tlb_pkg::INV_ALL_ALT: clr[i] = 1'b1;
                tlb_pkg::INV_GLOBAL:    clr[i] = m_entry_i[i].g;
                tlb_pkg::INV_NONGLOBAL: clr[i] = !m_entry_i[i].g;
                tlb_pkg::INV_ASID: begin
                    clr[i] = !m_entry_i[i].g && m_entry_i[i].asid == inv_asid_i;
                end
                tlb_pkg::INV_ASID_PAGE: begin
                    clr[i] = !m_entry_i[i].g && m_entry_i[i].asid == inv_asid_i &&
                             page_match(m_entry_i[i], inv_vppn_i);
                end
                tlb_pkg::INV_GASID_PAGE: begin
                    clr[i] = (m_entry_i[i].g || m_entry_i[i].asid == inv_asid_i) &&
                             page_match(m_entry_i[i], inv_vppn_i);
                end
                default: clr[i] = 1'b0;  // reserved ops
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cnt_q  <= '0;
            done_q <= 1'b0;
        end else if (!inv_en_i) begin
            cnt_q  <= '0;  // early drop restarts the walk
            done_q <= 1'b0;
        end else if (!done_q) begin
            cnt_q <= cnt_q + 1'b1;
            if (cnt_q == SET_W'(`TLB_NSET - 1)) begin
                done_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= '0;
        end else if (we_i) begin
            valid_q[w_index_i] <= w_e_i;  // write beats an inv step
        end else if (inv_step) begin
            for (int i = 0; i < `TLB_NWAY; i++) begin
                if (clr[i]) valid_q[{WAY_W'(i), cnt_q}] <= 1'b0;
            end
        end
    end

    assign valid_o = valid_q;

endmodule

/* hdl/tlb_way_ram.sv */
`timescale 1ns/1ps
`include "tlb_macros.svh"

module tlb_way_ram (
    input  logic                                clk,
    input  logic [$clog2(`TLB_NSET)-1:0]        s0_set_i,
    input  logic [$clog2(`TLB_NSET)-1:0]        s1_set_i,
    input  logic [$clog2(`TLB_NSET)-1:0]        m_set_i,
    input  logic                                we_i,
    input  logic [$clog2(`TLB_NSET)-1:0]        w_set_i,
    input  tlb_pkg::tlb_entry_t                 w_entry_i,
    output tlb_pkg::tlb_entry_t                 s0_entry_o,
    output tlb_pkg::tlb_entry_t                 s1_entry_o,
    output tlb_pkg::tlb_entry_t                 m_entry_o
);

    tlb_pkg::tlb_entry_t mem [`TLB_NSET];  // lut ram, no reset

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[w_set_i] <= w_entry_i;
        end
    end

    // async reads
    assign s0_entry_o = mem[s0_set_i];  // fetch side
    assign s1_entry_o = mem[s1_set_i];  // data side
    assign m_entry_o  = mem[m_set_i];   // read port / inv walk

endmodule

/* list.f */
+incdir+hdl
hdl/tlb_pkg.sv
hdl/tlb_way_ram.sv
hdl/tlb_search_stage.sv
hdl/tlb_valid_ctrl.sv
hdl/tlb_top.sv
tests/tlb_clkgen.sv
tests/tlb_sva.sv
tests/tlb_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module tlb_tb -f list.f -o tlb_sim \
    || { echo "build failed"; exit 1; }
./obj_dir/tlb_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST OK" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tests/tlb_clkgen.sv */
`timescale 1ns/1ps

module tlb_clkgen (
    output logic clk,
    output logic reset_o
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period
    end

    initial begin
        reset_o = 1'b1;
        repeat (5) @(posedge clk);
        #1 reset_o = 1'b0;
    end

endmodule

/* tests/tlb_sva.sv */
`timescale 1ns/1ps

module tlb_sva (
    input logic clk,
    input logic reset_i,
    input logic inv_en_i,
    input logic inv_stall_i,
    input logic s0_found_i,
    input logic s1_found_i
);

    logic [3:0] stall_run;  // consecutive stall cycles

    always_ff @(posedge clk) begin
        if (reset_i || !inv_stall_i) begin
            stall_run <= '0;
        end else if (stall_run != 4'hf) begin
            stall_run <= stall_run + 4'd1;
        end
    end

    stall_max_8: assert property (@(posedge clk) disable iff (reset_i)
        inv_stall_i |-> stall_run < 4'd8)
        else $error("inv_stall_o stayed high for more than 8 cycles");

    found_low_after_reset: assert property (@(posedge clk)
        reset_i |=> !s0_found_i && !s1_found_i)
        else $error("found_o high in the cycle after reset");

    stall_needs_en: assert property (@(posedge clk) disable iff (reset_i)
        !inv_en_i |-> !inv_stall_i)
        else $error("inv_stall_o high while inv_en_i is low");

endmodule

bind tlb_top tlb_sva sva0 (
    .clk         (clk),
    .reset_i     (reset_i),
    .inv_en_i    (inv_en_i),
    .inv_stall_i (inv_stall_o),
    .s0_found_i  (s0_found_o),
    .s1_found_i  (s1_found_o)
);

/* tests/tlb_tb.sv */
`timescale 1ns/1ps
`include "tlb_macros.svh"

module tlb_tb;

    localparam int N_ENT = `TLB_NWAY * `TLB_NSET;
    // tests need about 1600 cycles
    localparam int TIMEOUT_CYCLES = 4000;

    logic                clk;
    logic                reset;
    logic                fetch [2];
    logic [18:0]         vppn [2];
    logic                odd [2];
    logic [9:0]          asid [2];
    logic                found [2];
    logic [4:0]          index [2];
    logic [5:0]          ps [2];
    logic [19:0]         ppn [2];
    logic                v [2];
    logic                d [2];
    logic [1:0]          mat [2];
    logic [1:0]          plv [2];
    logic                we;
    logic [4:0]          w_index;
    tlb_pkg::tlb_entry_t w_entry;
    logic                w_e;
    logic [4:0]          r_index;
    tlb_pkg::tlb_entry_t r_entry;
    logic                r_e;
    logic                inv_en;
    tlb_pkg::tlb_inv_op_e inv_op;
    logic [9:0]          inv_asid;
    logic [18:0]         inv_vppn;
    logic                inv_stall;

    tlb_pkg::tlb_entry_t m_ent [N_ENT];  // reference model
    logic                m_e [N_ENT];
    logic                exp_found [2];
    logic [4:0]          exp_index [2];
    logic [31:0]         exp_fields [2];
    int                  n_checks = 0;
    int                  n_mismatch = 0;
    int                  cycles = 0;

    tlb_clkgen clkgen0 (.clk(clk), .reset_o(reset));

    tlb_top dut0 (
        .clk(clk), .reset_i(reset),
        .s0_fetch_i(fetch[0]), .s0_vppn_i(vppn[0]), .s0_odd_page_i(odd[0]),
        .s0_asid_i(asid[0]), .s0_found_o(found[0]), .s0_index_o(index[0]),
        .s0_ps_o(ps[0]), .s0_ppn_o(ppn[0]), .s0_v_o(v[0]), .s0_d_o(d[0]),
        .s0_mat_o(mat[0]), .s0_plv_o(plv[0]),
        .s1_fetch_i(fetch[1]), .s1_vppn_i(vppn[1]), .s1_odd_page_i(odd[1]),
        .s1_asid_i(asid[1]), .s1_found_o(found[1]), .s1_index_o(index[1]),
        .s1_ps_o(ps[1]), .s1_ppn_o(ppn[1]), .s1_v_o(v[1]), .s1_d_o(d[1]),
        .s1_mat_o(mat[1]), .s1_plv_o(plv[1]),
        .we_i(we), .w_index_i(w_index), .w_entry_i(w_entry), .w_e_i(w_e),
        .r_index_i(r_index), .r_entry_o(r_entry), .r_e_o(r_e),
        .inv_en_i(inv_en), .inv_op_i(inv_op), .inv_asid_i(inv_asid),
        .inv_vppn_i(inv_vppn), .inv_stall_o(inv_stall)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAILED");
            $finish;
        end
    end

    // 4K pages compare all of vppn, 4M pages only bits 18..9
    function automatic logic page_hit(tlb_pkg::tlb_entry_t e, logic [18:0] va);
        logic [18:0] mask;
        mask = (e.ps == 6'd22) ? 19'h7fe00 : 19'h7ffff;
        return ((e.vppn ^ va) & mask) == 19'd0;
    endfunction

    function automatic int model_lookup(logic [18:0] va, logic [9:0] as);
        int hit = -1;
        for (int w = 0; w < `TLB_NWAY; w++) begin
            int i = w * `TLB_NSET + int'(va[11:9]);
            if (m_e[i] && page_hit(m_ent[i], va) && (m_ent[i].g || m_ent[i].asid == as)) begin
                hit = i;  // later way wins
            end
        end
        return hit;
    endfunction

    function automatic logic [31:0] half_fields(tlb_pkg::tlb_entry_t e, logic odd_sel);
        if (odd_sel) return {e.ps, e.ppn1, e.v1, e.d1, e.mat1, e.plv1};
        return {e.ps, e.ppn0, e.v0, e.d0, e.mat0, e.plv0};
    endfunction

    function automatic tlb_pkg::tlb_entry_t rand_entry(int idx, bit big, int g_pct);
        tlb_pkg::tlb_entry_t e;
        e      = 88'({$urandom(), $urandom(), $urandom()});
        e.ps   = big ? 6'd22 : 6'd12;
        e.g    = ($urandom() % 100) < g_pct;
        e.asid = 10'($urandom() % 4);
        e.vppn = {7'($urandom() % 4), 3'(idx), 9'($urandom() % 4)};
        if ($urandom() % 8 == 0) e.vppn[11:9] = 3'(idx + 1 + $urandom() % 7);  // wrong set
        return e;
    endfunction

    task automatic write_entry(int idx, tlb_pkg::tlb_entry_t e, logic e_bit);
        we      = 1'b1;
        w_index = 5'(idx);
        w_entry = e;
        w_e     = e_bit;
        @(posedge clk);
        #1;
        we         = 1'b0;
        m_ent[idx] = e;
        m_e[idx]   = e_bit;
    endtask

    task automatic fill_table(int mode, int g_pct);
        bit big;
        for (int i = 0; i < N_ENT; i++) begin
            big = (mode == 2) ? 1'($urandom()) : (mode == 1);
            write_entry(i, rand_entry(i, big, g_pct), ($urandom() % 8) != 0);
        end
    endtask

    task automatic read_all(string name, bit with_entry);
        for (int i = 0; i < N_ENT; i++) begin
            r_index = 5'(i);
            #1;
            n_checks++;
            if (r_e !== m_e[i]) begin
                $display("mismatch %s e[%0d]: expected %0b, actual %0b", name, i, m_e[i], r_e);
                n_mismatch++;
            end
            if (with_entry && r_entry !== m_ent[i]) begin
                $display("mismatch %s entry[%0d]: expected %h, actual %h",
                         name, i, m_ent[i], r_entry);
                n_mismatch++;
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic drive_query(int p, int hit_pct);
        tlb_pkg::tlb_entry_t e;
        logic [18:0]         va;
        logic [9:0]          as;
        logic                od;
        int                  hit;
        e  = m_ent[$urandom() % N_ENT];
        va = {7'($urandom() % 4), 3'($urandom()), 9'($urandom() % 4)};
        as = 10'($urandom() % 4);
        od = 1'($urandom());
        if ($urandom() % 100 < hit_pct) begin
            va = e.vppn;  // aim at a stored entry
            if (e.ps == 6'd22) va[8:0] = 9'($urandom());
            as = e.g ? 10'(4 + $urandom() % 1020) : e.asid;
        end
        if (p == 1 && va == vppn[0]) va[12] = ~va[12];
        hit          = model_lookup(va, as);
        fetch[p]     = 1'b1;
        vppn[p]      = va;
        odd[p]       = od;
        asid[p]      = as;
        exp_found[p] = hit >= 0;
        if (hit >= 0) begin
            exp_index[p]  = 5'(hit);
            exp_fields[p] = half_fields(m_ent[hit], (m_ent[hit].ps == 6'd22) ? va[8] : od);
        end
    endtask

    task automatic check_port(string name, int p);
        n_checks++;
        if (found[p] !== exp_found[p]) begin
            $display("mismatch %s port%0d found: expected %0b, actual %0b",
                     name, p, exp_found[p], found[p]);
            n_mismatch++;
        end else if (exp_found[p]) begin
            if (index[p] !== exp_index[p]) begin
                $display("mismatch %s port%0d index: expected %0d, actual %0d",
                         name, p, exp_index[p], index[p]);
                n_mismatch++;
            end
            if ({ps[p], ppn[p], v[p], d[p], mat[p], plv[p]} !== exp_fields[p]) begin
                $display("mismatch %s port%0d fields: expected %h, actual %h", name, p,
                         exp_fields[p], {ps[p], ppn[p], v[p], d[p], mat[p], plv[p]});
                n_mismatch++;
            end
        end
    endtask

    // result of cycle k is checked at k+1; idle cycles check the hold
    task automatic search_burst(string name, int n, int hit_pct, bit with_idle);
        for (int k = 0; k <= n; k++) begin
            for (int p = 0; p < 2; p++) begin
                if (k > 0) check_port(name, p);
                fetch[p] = 1'b0;
                if (k < n && (!with_idle || $urandom() % 4 != 0)) drive_query(p, hit_pct);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic run_invalidate(int op);
        int                  stall_cycles;
        logic                clr;
        logic                own;
        tlb_pkg::tlb_entry_t e;
        inv_en   = 1'b1;
        inv_op   = tlb_pkg::tlb_inv_op_e'(op);
        inv_asid = 10'($urandom() % 4);
        inv_vppn = m_ent[$urandom() % N_ENT].vppn;
        if ($urandom() % 2 == 0) inv_vppn[8:0] = 9'($urandom());
        stall_cycles = 0;
        @(negedge clk);
        while (inv_stall) begin
            stall_cycles++;
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        inv_en = 1'b0;
        n_checks++;
        if (stall_cycles != 8) begin
            $display("mismatch inv_op%0d stall: expected 8, actual %0d", op, stall_cycles);
            n_mismatch++;
        end
        for (int i = 0; i < N_ENT; i++) begin
            e   = m_ent[i];
            own = e.asid == inv_asid;
            case (op)
                0, 1:    clr = 1'b1;
                2:       clr = e.g;
                3:       clr = !e.g;
                4:       clr = !e.g && own;
                5:       clr = !e.g && own && page_hit(e, inv_vppn);
                default: clr = (e.g || own) && page_hit(e, inv_vppn);
            endcase
            if (clr) m_e[i] = 1'b0;
        end
    endtask

    initial begin
        int idx;
        void'($urandom(58383));
        for (int p = 0; p < 2; p++) begin
            fetch[p]     = 1'b0;
            vppn[p]      = '0;
            odd[p]       = 1'b0;
            asid[p]      = '0;
            exp_found[p] = 1'b0;
        end
        we       = 1'b0;
        w_index  = '0;
        w_entry  = '0;
        w_e      = 1'b0;
        r_index  = '0;
        inv_en   = 1'b0;
        inv_op   = tlb_pkg::INV_ALL;
        inv_asid = '0;
        inv_vppn = '0;
        for (int i = 0; i < N_ENT; i++) begin
            m_ent[i] = '0;
            m_e[i]   = 1'b0;
        end
        @(negedge reset);

        search_burst("reset_search", 10, 0, 1'b0);
        read_all("reset_read", 1'b0);

        fill_table(0, 0);
        for (int k = 0; k < 32; k++) begin
            idx = $urandom() % N_ENT;
            write_entry(idx, rand_entry(idx, 1'b0, 0), ($urandom() % 4) != 0);
        end
        read_all("write_read", 1'b1);

        search_burst("search_4k", 200, 50, 1'b1);

        fill_table(1, 50);
        search_burst("search_4m_global", 200, 50, 1'b1);

        for (int op = 0; op <= 6; op++) begin
            fill_table(2, 50);
            run_invalidate(op);
            read_all($sformatf("inv_op%0d_read", op), 1'b1);
            search_burst($sformatf("inv_op%0d_search", op), 30, 50, 1'b1);
        end

        fill_table(2, 30);
        search_burst("dual_port", 200, 50, 1'b0);

        $display("checks %0d, mismatches %0d", n_checks, n_mismatch);
        if (n_mismatch == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
